//--- list.f
verilog/axi_bridge_pkg.sv
verilog/resp_fifo.sv
verilog/sram_axi_bridge.sv
verilog/axi_ram.sv
verilog/axi_sram_top.sv
tb/tb_axi_sram.sv

//--- Makefile
TOP := tb_axi_sram

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "ERRORS FOUND" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" sim.log || (echo "no pass line in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- tb/tb_axi_sram.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_sram;
    import axi_bridge_pkg::*;

    localparam int MAX_READS      = 2;
    localparam int MEM_WORDS      = 256;
    localparam int FIFO_DEPTH     = 4;
    localparam int IDX_W          = $clog2(MEM_WORDS);
    localparam int SEED           = 22393;
    localparam int RESET_CYCLES   = 4;
    localparam int BASE_WORD      = 32;    // hazard window
    localparam int WINDOW         = 16;
    localparam int RACE_PAIRS     = 8;
    localparam int INST_TXN       = 84;
    localparam int DATA_TXN       = 84;
    localparam int NUM_TXN        = WINDOW + 2 * RACE_PAIRS + INST_TXN + DATA_TXN;
    localparam int TIMEOUT_CYCLES = NUM_TXN * 20 + RESET_CYCLES;

    logic      aclk;
    logic      reset;
    sram_req_t inst_req;
    logic      inst_req_valid;
    sram_req_t data_req;
    logic      data_req_valid;
    logic      inst_addr_ok;
    logic      data_addr_ok;
    logic      inst_data_ok;
    logic      data_data_ok;
    sram_rsp_t inst_rsp;
    sram_rsp_t data_rsp;

    logic [31:0] model_mem [MEM_WORDS];
    sram_rsp_t   inst_exp_q[$];
    sram_rsp_t   data_exp_q[$];
    sram_req_t   data_req_q[$];    // accepted data requests still waiting for data_ok
    int          cycle_cnt = 0;

    axi_sram_top #(
        .MAX_READS  (MAX_READS),
        .MEM_WORDS  (MEM_WORDS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_dut (
        .aclk, .reset,
        .inst_req, .inst_req_valid, .data_req, .data_req_valid,
        .inst_addr_ok, .data_addr_ok, .inst_data_ok, .data_data_ok,
        .inst_rsp, .data_rsp
    );

    initial
    begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    task automatic fail_stop();
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_rsp(input string name, input sram_rsp_t exp, input sram_rsp_t act);
        if (act !== exp)
        begin
            $display("Fail %s: expected rdata %h err %b, actual rdata %h err %b",
                     name, exp.rdata, exp.err, act.rdata, act.err);
            fail_stop();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            fail_stop();
        end
    endtask

    function automatic logic in_range(input logic [31:0] addr);
        return (addr >> 2) < 32'(MEM_WORDS);
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9E37_79B1) ^ 32'hC3A5_0F1E;
    endfunction

    function automatic sram_rsp_t expect_read(input logic [31:0] addr);
        sram_rsp_t rsp;
        if (in_range(addr))
            rsp = '{rdata: model_mem[addr[IDX_W+1:2]], err: 1'b0};
        else
            rsp = '{rdata: 32'd0, err: 1'b1};    // SLVERR carries no data
        return rsp;
    endfunction

    function automatic sram_rsp_t write_rsp(input logic [31:0] addr);
        return '{rdata: 32'd0, err: !in_range(addr)};
    endfunction

    // write to the same word still waiting for its response
    function automatic logic write_waiting(input logic [31:0] addr);
        logic hit;
        hit = 1'b0;
        foreach (data_req_q[i])
        begin
            if (data_req_q[i].wr && data_req_q[i].addr[31:2] == addr[31:2])
                hit = 1'b1;
        end
        return hit;
    endfunction

    // byte merge under the strobes
    function automatic void apply_write(input sram_req_t req);
        if (in_range(req.addr))
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (req.wstrb[i])
                    model_mem[req.addr[IDX_W+1:2]][8*i +: 8] = req.wdata[8*i +: 8];
            end
        end
    endfunction

    function automatic logic [31:0] rand_addr(input logic allow_oob);
        int unsigned idx;
        if (allow_oob && $urandom_range(15, 0) == 0)
            idx = MEM_WORDS + $urandom_range(63, 0);
        else
            idx = BASE_WORD + $urandom_range(WINDOW - 1, 0);
        return idx << 2;
    endfunction

    function automatic sram_req_t make_req(input logic wr, input logic [31:0] addr,
                                           input logic [3:0] strb, input logic [31:0] data);
        sram_req_t req;
        req.wr    = wr;
        req.size  = 3'd2;
        req.addr  = addr;
        req.wstrb = strb;
        req.wdata = data;
        return req;
    endfunction

    // holds the request until addr_ok, then idles for gap cycles
    task automatic send_req(input logic on_data, input sram_req_t req, input int gap);
        @(negedge aclk);
        if (on_data)
        begin
            data_req       = req;
            data_req_valid = 1'b1;
        end
        else
        begin
            inst_req       = req;
            inst_req_valid = 1'b1;
        end
        @(posedge aclk);
        while (!(on_data ? data_addr_ok : inst_addr_ok))
            @(posedge aclk);
        repeat (gap)
        begin
            @(negedge aclk);
            if (on_data)
                data_req_valid = 1'b0;
            else
                inst_req_valid = 1'b0;
        end
    endtask

    task automatic inst_traffic(input int count);
        for (int n = 0; n < count; n++)
            send_req(1'b0, make_req(1'b0, rand_addr(1'b1), 4'h0, 32'h0), $urandom_range(2, 0));
        @(negedge aclk);
        inst_req_valid = 1'b0;
    endtask

    task automatic data_traffic(input int count);
        sram_req_t   req;
        logic [31:0] last_wr;
        logic        follow;
        follow  = 1'b0;
        last_wr = '0;
        for (int n = 0; n < count; n++)
        begin
            if (follow)
            begin
                req    = make_req(1'b0, last_wr, 4'h0, 32'h0);    // read behind the write
                follow = 1'b0;
            end
            else if ($urandom_range(9, 0) < 4)
            begin
                req     = make_req(1'b1, rand_addr(1'b1), 4'($urandom_range(15, 0)), $urandom);
                last_wr = req.addr;
                follow  = ($urandom_range(1, 0) == 1);
            end
            else
                req = make_req(1'b0, rand_addr(1'b1), 4'h0, 32'h0);
            send_req(1'b1, req, $urandom_range(2, 0));
        end
        @(negedge aclk);
        data_req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (inst_exp_q.size() != 0 || data_exp_q.size() != 0)
            @(posedge aclk);
    endtask

    // both ports ask in the same cycle on an idle bridge
    task automatic race_reads(input logic [31:0] inst_addr, input logic [31:0] data_addr);
        wait_idle();
        @(negedge aclk);
        inst_req       = make_req(1'b0, inst_addr, 4'h0, 32'h0);
        inst_req_valid = 1'b1;
        data_req       = make_req(1'b0, data_addr, 4'h0, 32'h0);
        data_req_valid = 1'b1;
        @(posedge aclk);
        check_flag("race data_addr_ok", 1'b1, data_addr_ok);
        check_flag("race inst_addr_ok", 1'b0, inst_addr_ok);
        @(negedge aclk);
        data_req_valid = 1'b0;
        @(posedge aclk);
        while (!inst_addr_ok)
            @(posedge aclk);
        @(negedge aclk);
        inst_req_valid = 1'b0;
    endtask

    always @(posedge aclk)
    begin
        if (!reset)
        begin
            // the read waits until the write's response has come back
            if (data_req_valid && !data_req.wr && write_waiting(data_req.addr))
                check_flag("hazard data_addr_ok", 1'b0, data_addr_ok);
            // inst first since a read in a write's commit cycle still sees the old word
            if (inst_addr_ok)
                inst_exp_q.push_back(expect_read(inst_req.addr));
            if (data_addr_ok)
            begin
                data_req_q.push_back(data_req);
                if (data_req.wr)
                begin
                    data_exp_q.push_back(write_rsp(data_req.addr));
                    apply_write(data_req);
                end
                else
                    data_exp_q.push_back(expect_read(data_req.addr));
            end
            if (inst_data_ok)
            begin
                if (inst_exp_q.size() == 0)
                begin
                    $display("inst_data_ok pulsed with no accepted request waiting");
                    fail_stop();
                end
                else
                    check_rsp("inst response", inst_exp_q.pop_front(), inst_rsp);
            end
            if (data_data_ok)
            begin
                if (data_exp_q.size() == 0)
                begin
                    $display("data_data_ok pulsed with no accepted request waiting");
                    fail_stop();
                end
                else
                begin
                    data_req_q.delete(0);
                    check_rsp("data response", data_exp_q.pop_front(), data_rsp);
                end
            end
        end
    end

    always @(posedge aclk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
            fail_stop();
        end
    end

    initial
    begin
        void'($urandom(SEED));
        reset          = 1'b1;
        inst_req       = '0;
        inst_req_valid = 1'b0;
        data_req       = '0;
        data_req_valid = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        @(negedge aclk);
        reset = 1'b0;

        repeat (2)
        begin
            @(posedge aclk);
            check_flag("idle inst_addr_ok", 1'b0, inst_addr_ok);
            check_flag("idle data_addr_ok", 1'b0, data_addr_ok);
            check_flag("idle inst_data_ok", 1'b0, inst_data_ok);
            check_flag("idle data_data_ok", 1'b0, data_data_ok);
        end

        // known contents for the whole window
        for (int k = 0; k < WINDOW; k++)
            send_req(1'b1, make_req(1'b1, 32'(BASE_WORD + k) << 2, 4'hf,
                                    fill_word(32'(BASE_WORD + k) << 2)), 0);

        fork
            inst_traffic(INST_TXN);
            data_traffic(DATA_TXN);
        join

        for (int k = 0; k < RACE_PAIRS; k++)
            race_reads(rand_addr(1'b0), rand_addr(1'b0));

        wait_idle();
        repeat (10) @(posedge aclk);    // catch stray data_ok
        if (inst_exp_q.size() != 0 || data_exp_q.size() != 0)
        begin
            $display("responses still outstanding at end of run");
            fail_stop();
        end
        else
        begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verilog/axi_sram_top.sv
`timescale 1ns/1ps
`default_nettype none

module axi_sram_top #(
    parameter int MAX_READS  = 2,
    parameter int MEM_WORDS  = 256,
    parameter int FIFO_DEPTH = 4
) (
    input  wire                         aclk,
    input  wire                         reset,
    input  wire axi_bridge_pkg::sram_req_t inst_req,
    input  wire                         inst_req_valid,
    input  wire axi_bridge_pkg::sram_req_t data_req,
    input  wire                         data_req_valid,
    output logic                        inst_addr_ok,
    output logic                        data_addr_ok,
    output logic                        inst_data_ok,
    output logic                        data_data_ok,
    output axi_bridge_pkg::sram_rsp_t   inst_rsp,
    output axi_bridge_pkg::sram_rsp_t   data_rsp
);
    import axi_bridge_pkg::*;

    axi_ar_t ar;
    logic    arvalid;
    logic    arready;
    axi_aw_t aw;
    logic    awvalid;
    logic    awready;
    axi_w_t  w;
    logic    wvalid;
    logic    wready;
    axi_r_t  r;
    logic    rvalid;
    logic    rready;
    axi_b_t  b;
    logic    bvalid;
    logic    bready;

    sram_axi_bridge #(
        .MAX_READS (MAX_READS)
    ) i_bridge (
        .aclk, .reset,
        .inst_req, .inst_req_valid, .data_req, .data_req_valid,
        .inst_addr_ok, .data_addr_ok, .inst_data_ok, .data_data_ok,
        .inst_rsp, .data_rsp,
        .ar, .arvalid, .arready, .aw, .awvalid, .awready,
        .w, .wvalid, .wready, .r, .rvalid, .rready, .b, .bvalid, .bready
    );

    axi_ram #(
        .MEM_WORDS  (MEM_WORDS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_ram (
        .aclk, .reset,
        .ar, .arvalid, .arready, .aw, .awvalid, .awready,
        .w, .wvalid, .wready, .r, .rvalid, .rready, .b, .bvalid, .bready
    );

endmodule

`default_nettype wire

//--- verilog/axi_ram.sv
`timescale 1ns/1ps
`default_nettype none

module axi_ram #(
    parameter int MEM_WORDS  = 256,
    parameter int FIFO_DEPTH = 4
) (
    input  wire                       aclk,
    input  wire                       reset,
    input  wire axi_bridge_pkg::axi_ar_t ar,
    input  wire                       arvalid,
    output logic                      arready,
    input  wire axi_bridge_pkg::axi_aw_t aw,
    input  wire                       awvalid,
    output logic                      awready,
    input  wire axi_bridge_pkg::axi_w_t  w,
    input  wire                       wvalid,
    output logic                      wready,
    output axi_bridge_pkg::axi_r_t    r,
    output logic                      rvalid,
    input  wire                       rready,
    output axi_bridge_pkg::axi_b_t    b,
    output logic                      bvalid,
    input  wire                       bready
);
    import axi_bridge_pkg::*;

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    logic [31:0] mem [MEM_WORDS];

    ram_wr_state_e wr_state;
    axi_aw_t       aw_q;
    axi_w_t        w_q;
    axi_b_t        b_q;

    logic    fifo_full;
    logic    fifo_empty;
    logic    ar_hs;
    logic    aw_hs;
    logic    w_hs;
    logic    wr_commit;
    logic    rd_in_range;
    logic    wr_in_range;
    axi_r_t  rd_rsp;
    axi_aw_t wr_aw;
    axi_w_t  wr_w;

    assign arready     = !fifo_full;
    assign ar_hs       = arvalid && arready;
    assign rd_in_range = (ar.addr >> 2) < 32'(MEM_WORDS);

    always_comb
    begin
        rd_rsp.id = ar.id;
        if (rd_in_range)
        begin
            rd_rsp.data = mem[ar.addr[IDX_W+1:2]];
            rd_rsp.resp = OKAY;
        end
        else
        begin
            rd_rsp.data = 32'd0;
            rd_rsp.resp = SLVERR;
        end
    end

    resp_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_resp_fifo (
        .aclk      (aclk),
        .reset     (reset),
        .push_data (rd_rsp),
        .push      (ar_hs),
        .pop       (rvalid && rready),
        .head      (r),
        .empty     (fifo_empty),
        .full      (fifo_full)
    );

    assign rvalid = !fifo_empty;

    // one write at a time, aw and w in either order
    assign awready = (wr_state == RW_IDLE) || (wr_state == RW_HAVE_W);
    assign wready  = (wr_state == RW_IDLE) || (wr_state == RW_HAVE_AW);
    assign aw_hs   = awvalid && awready;
    assign w_hs    = wvalid && wready;

    assign wr_aw = (wr_state == RW_HAVE_AW) ? aw_q : aw;
    assign wr_w  = (wr_state == RW_HAVE_W) ? w_q : w;

    assign wr_commit = (wr_state == RW_IDLE && aw_hs && w_hs) ||
                       (wr_state == RW_HAVE_AW && w_hs) ||
                       (wr_state == RW_HAVE_W && aw_hs);
    assign wr_in_range = (wr_aw.addr >> 2) < 32'(MEM_WORDS);

    always_ff @(posedge aclk)
    begin
        if (reset)
            wr_state <= RW_IDLE;
        else if (wr_commit)
            wr_state <= RW_RESP;
        else if (wr_state == RW_IDLE && aw_hs)
            wr_state <= RW_HAVE_AW;
        else if (wr_state == RW_IDLE && w_hs)
            wr_state <= RW_HAVE_W;
        else if (wr_state == RW_RESP && bready)
            wr_state <= RW_IDLE;
    end

    always_ff @(posedge aclk)
    begin
        if (aw_hs)
            aw_q <= aw;
        if (w_hs)
            w_q <= w;
        if (wr_commit)
        begin
            b_q <= '{id: wr_aw.id, resp: wr_in_range ? OKAY : SLVERR};
            if (wr_in_range)
            begin
                for (int i = 0; i < 4; i++)
                begin
                    if (wr_w.strb[i])
                        mem[wr_aw.addr[IDX_W+1:2]][8*i +: 8] <= wr_w.data[8*i +: 8];
                end
            end
        end
    end

    assign b      = b_q;
    assign bvalid = (wr_state == RW_RESP);

    b_hold: assert property (@(posedge aclk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(b));

endmodule

`default_nettype wire

//--- verilog/sram_axi_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module sram_axi_bridge #(
    parameter int MAX_READS = 2
) (
    input  wire                         aclk,
    input  wire                         reset,
    input  wire axi_bridge_pkg::sram_req_t inst_req,
    input  wire                         inst_req_valid,
    input  wire axi_bridge_pkg::sram_req_t data_req,
    input  wire                         data_req_valid,
    output logic                        inst_addr_ok,
    output logic                        data_addr_ok,
    output logic                        inst_data_ok,
    output logic                        data_data_ok,
    output axi_bridge_pkg::sram_rsp_t   inst_rsp,
    output axi_bridge_pkg::sram_rsp_t   data_rsp,
    output axi_bridge_pkg::axi_ar_t     ar,
    output logic                        arvalid,
    input  wire                         arready,
    output axi_bridge_pkg::axi_aw_t     aw,
    output logic                        awvalid,
    input  wire                         awready,
    output axi_bridge_pkg::axi_w_t      w,
    output logic                        wvalid,
    input  wire                         wready,
    input  wire axi_bridge_pkg::axi_r_t r,
    input  wire                         rvalid,
    output logic                        rready,
    input  wire axi_bridge_pkg::axi_b_t b,
    input  wire                         bvalid,
    output logic                        bready
);
    import axi_bridge_pkg::*;

    localparam int CNT_W = $clog2(MAX_READS + 1);

    rd_state_e        rd_state;
    wr_state_e        wr_state;
    logic             hold_data;    // port locked in while in RD_HOLD
    logic [CNT_W-1:0] out_cnt;      // reads past AR, waiting for R

    logic      data_rd;
    logic      data_wr;
    logic      sel_data;
    logic      rd_want;
    logic      rd_blocked;
    logic      ar_hs;
    logic      r_hs;
    logic      aw_hs;
    logic      w_hs;
    logic      b_hs;
    logic      wr_accept;
    sram_req_t rd_src;

    assign data_rd = data_req_valid && !data_req.wr;
    assign data_wr = data_req_valid && data_req.wr;

    // data port first, instruction port only reads
    assign sel_data = (rd_state == RD_HOLD) ? hold_data : data_rd;
    assign rd_want  = sel_data ? data_rd : inst_req_valid;

    // a pending write stalls data reads, which covers the RAW hazard
    // and keeps data_ok in request order on the data port
    assign rd_blocked = (out_cnt == CNT_W'(MAX_READS)) || (sel_data && wr_state != WR_IDLE);

    assign arvalid = rd_want && !rd_blocked;
    assign rd_src  = sel_data ? data_req : inst_req;
    assign ar      = '{id: sel_data ? ID_DATA : ID_INST, addr: rd_src.addr, size: rd_src.size};

    assign ar_hs  = arvalid && arready;
    assign r_hs   = rvalid && rready;
    assign rready = (out_cnt != '0);

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            rd_state  <= RD_IDLE;
            hold_data <= 1'b0;
        end
        else
        begin
            case (rd_state)
                RD_IDLE:
                begin
                    // freeze the choice once arvalid is up or a data read stalls
                    if (rd_want && !ar_hs && (arvalid || sel_data))
                    begin
                        rd_state  <= RD_HOLD;
                        hold_data <= sel_data;
                    end
                end
                RD_HOLD:
                begin
                    if (ar_hs)
                        rd_state <= RD_IDLE;
                end
                default:
                    rd_state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if (reset)
            out_cnt <= '0;
        else if (ar_hs && !r_hs)
            out_cnt <= out_cnt + 1'b1;
        else if (r_hs && !ar_hs)
            out_cnt <= out_cnt - 1'b1;
    end

    assign awvalid = (wr_state == WR_BOTH) || (wr_state == WR_W_DONE);
    assign wvalid  = (wr_state == WR_BOTH) || (wr_state == WR_AW_DONE);
    assign aw      = '{id: ID_DATA, addr: data_req.addr, size: data_req.size};
    assign w       = '{data: data_req.wdata, strb: data_req.wstrb};
    assign bready  = (wr_state == WR_RESP);

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign b_hs  = bvalid && bready;

    // second of the two handshakes, or both at once
    assign wr_accept = (wr_state == WR_BOTH && aw_hs && w_hs) ||
                       (wr_state == WR_AW_DONE && w_hs) ||
                       (wr_state == WR_W_DONE && aw_hs);

    always_ff @(posedge aclk)
    begin
        if (reset)
            wr_state <= WR_IDLE;
        else
        begin
            case (wr_state)
                WR_IDLE:
                begin
                    if (data_wr && out_cnt == '0)    // earlier data reads drain first
                        wr_state <= WR_BOTH;
                end
                WR_BOTH:
                begin
                    if (aw_hs && w_hs)
                        wr_state <= WR_RESP;
                    else if (aw_hs)
                        wr_state <= WR_AW_DONE;
                    else if (w_hs)
                        wr_state <= WR_W_DONE;
                end
                WR_AW_DONE:
                begin
                    if (w_hs)
                        wr_state <= WR_RESP;
                end
                WR_W_DONE:
                begin
                    if (aw_hs)
                        wr_state <= WR_RESP;
                end
                WR_RESP:
                begin
                    if (b_hs)
                        wr_state <= WR_IDLE;
                end
                default:
                    wr_state <= WR_IDLE;
            endcase
        end
    end

    assign inst_addr_ok = ar_hs && !sel_data;
    assign data_addr_ok = (ar_hs && sel_data) || wr_accept;
    assign inst_data_ok = r_hs && (r.id == ID_INST);
    assign data_data_ok = (r_hs && r.id == ID_DATA) || (b_hs && b.id == ID_DATA);

    assign inst_rsp = '{rdata: r.data, err: r.resp != OKAY};

    always_comb
    begin
        if (b_hs)
            data_rsp = '{rdata: 32'd0, err: b.resp != OKAY};
        else
            data_rsp = '{rdata: r.data, err: r.resp != OKAY};
    end

    ar_stable: assert property (@(posedge aclk) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(ar));

    reads_limit: assert property (@(posedge aclk) disable iff (reset)
        out_cnt <= CNT_W'(MAX_READS));

endmodule

`default_nettype wire

//--- verilog/resp_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module resp_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire                      aclk,
    input  wire                      reset,
    input  wire axi_bridge_pkg::axi_r_t push_data,
    input  wire                      push,
    input  wire                      pop,
    output axi_bridge_pkg::axi_r_t   head,
    output logic                     empty,
    output logic                     full
);
    import axi_bridge_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    axi_r_t           mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge aclk)
    begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= ptr_next(wr_ptr);
            if (pop)
                rd_ptr <= ptr_next(rd_ptr);
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(FIFO_DEPTH));

    // arready upstream has to follow full
    no_overflow: assert property (@(posedge aclk) disable iff (reset) push |-> !full);
    no_underflow: assert property (@(posedge aclk) disable iff (reset) pop |-> !empty);

endmodule

`default_nettype wire

//--- verilog/axi_bridge_pkg.sv
`default_nettype none

package axi_bridge_pkg;

    localparam logic [3:0] ID_INST = 4'd0;
    localparam logic [3:0] ID_DATA = 4'd1;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    typedef enum logic {
        RD_IDLE,
        RD_HOLD
    } rd_state_e;

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_BOTH,
        WR_AW_DONE,
        WR_W_DONE,
        WR_RESP
    } wr_state_e;

    typedef enum logic [1:0] {
        RW_IDLE,
        RW_HAVE_AW,
        RW_HAVE_W,
        RW_RESP
    } ram_wr_state_e;

    typedef struct packed {
        logic        wr;
        logic [2:0]  size;
        logic [31:0] addr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } sram_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;    // resp was not OKAY
    } sram_rsp_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] addr;
        logic [2:0]  size;
    } axi_ar_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] addr;
        logic [2:0]  size;
    } axi_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axi_w_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] data;
        axi_resp_e   resp;
    } axi_r_t;

    typedef struct packed {
        logic [3:0] id;
        axi_resp_e  resp;
    } axi_b_t;

endpackage

`default_nettype wire
